// File: design/icachePkg.sv
package icachePkg;

  // cache geometry
  localparam int AddrWidth    = 32;
  localparam int XLen         = 64;
  localparam int TagWidth     = 21;
  localparam int IndexWidth   = 6;
  localparam int OffsetWidth  = 5;
  localparam int NumSets      = 64;
  localparam int BeatsPerLine = 4;
  localparam int LineWidth    = 256;

  // config register numbers
  // ctrl bit 0 is enable, bit 1 is flush (write one, self clearing)
  localparam logic [1:0] CfgCtrl      = 2'd0;
  localparam logic [1:0] CfgHitCount  = 2'd1;
  localparam logic [1:0] CfgMissCount = 2'd2;

  // controller state encoding
  localparam logic [2:0] StIdle    = 3'd0;
  localparam logic [2:0] StCompare = 3'd1;
  localparam logic [2:0] StMiss    = 3'd2;
  localparam logic [2:0] StFetch   = 3'd3;
  localparam logic [2:0] StReplace = 3'd4;
  localparam logic [2:0] StFlush   = 3'd5;

  // fetch address, seen as a raw word or split into fields
  typedef union packed {
    logic [AddrWidth-1:0] word;
    struct packed {
      logic [TagWidth-1:0]   tag;
      logic [IndexWidth-1:0] index;
      logic [1:0]            beatSel;
      logic [2:0]            byteOff;
    } f;
  } cacheAddrT;

endpackage

// File: design/icacheTagArray.sv
module icacheTagArray (
  input  logic                 clk,
  input  logic                 rst_n,
  input  icachePkg::cacheAddrT lookupAddr_i,
  input  logic                 tagWe_i,
  input  logic                 weWay_i,
  input  logic                 flushAll_i,
  output logic                 way0Hit_o,
  output logic                 way1Hit_o,
  output logic                 victim_o
);

  icachePkg::cacheAddrT curAddr;
  logic [icachePkg::TagWidth-1:0] tagMem [2][icachePkg::NumSets];
  logic [icachePkg::NumSets-1:0]  validQ [2];
  logic [icachePkg::NumSets-1:0]  rrQ;
  logic [1:0]                     wayHit;

  // lookup address of the request now in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curAddr <= '0;
    end else begin
      curAddr <= lookupAddr_i;
    end
  end

  for (genvar w = 0; w < 2; w++) begin : gWay
    always_ff @(posedge clk) begin
      if (tagWe_i && weWay_i == 1'(w)) begin
        tagMem[w][curAddr.f.index] <= curAddr.f.tag;
      end
    end

    // flush drops every line of the way at once
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        validQ[w] <= '0;
      end else if (flushAll_i) begin
        validQ[w] <= '0;
      end else if (tagWe_i && weWay_i == 1'(w)) begin
        validQ[w][curAddr.f.index] <= 1'b1;
      end
    end

    assign wayHit[w] = validQ[w][curAddr.f.index] &&
                       (tagMem[w][curAddr.f.index] == curAddr.f.tag);
  end

  // round-robin victim, flips on each fill, kept across a flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rrQ <= '0;
    end else if (tagWe_i) begin
      rrQ[curAddr.f.index] <= ~rrQ[curAddr.f.index];
    end
  end

  assign way0Hit_o = wayHit[0];
  assign way1Hit_o = wayHit[1];
  assign victim_o  = rrQ[curAddr.f.index];

  // a line is only ever filled into the way that missed on both
  aOneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(way0Hit_o && way1Hit_o));

endmodule

// File: design/icacheDataArray.sv
module icacheDataArray (
  input  logic                            clk,
  input  icachePkg::cacheAddrT            rdAddr_i,
  input  icachePkg::cacheAddrT            wrAddr_i,
  input  logic                            we_i,
  input  logic                            weWay_i,
  input  logic [icachePkg::LineWidth-1:0] lineData_i,
  input  logic                            hitWay1_i,
  output logic [icachePkg::XLen-1:0]      word_o
);

  logic [icachePkg::LineWidth-1:0] lineMem [2][icachePkg::NumSets];
  logic [icachePkg::LineWidth-1:0] rdLine [2];
  logic [1:0]                      beatSelQ;

  for (genvar w = 0; w < 2; w++) begin : gWay
    always_ff @(posedge clk) begin
      if (we_i && weWay_i == 1'(w)) begin
        lineMem[w][wrAddr_i.f.index] <= lineData_i;
      end
    end

    // registered read, new line passed through while it is written
    always_ff @(posedge clk) begin
      if (we_i && weWay_i == 1'(w) && wrAddr_i.f.index == rdAddr_i.f.index) begin
        rdLine[w] <= lineData_i;
      end else begin
        rdLine[w] <= lineMem[w][rdAddr_i.f.index];
      end
    end
  end

  always_ff @(posedge clk) begin
    beatSelQ <= rdAddr_i.f.beatSel;
  end

  assign word_o = hitWay1_i ? rdLine[1][beatSelQ*icachePkg::XLen +: icachePkg::XLen]
                            : rdLine[0][beatSelQ*icachePkg::XLen +: icachePkg::XLen];

endmodule

// File: design/icacheRefill.sv
module icacheRefill (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start_i,
  input  icachePkg::cacheAddrT            lineAddr_i,
  output logic                            memRdValid_o,
  input  logic                            memRdReady_i,
  output logic [icachePkg::AddrWidth-1:0] memAddr_o,
  input  logic [icachePkg::XLen-1:0]      memData_i,
  input  logic                            memDataValid_i,
  input  logic                            memLast_i,
  output logic                            done_o,
  output logic [icachePkg::LineWidth-1:0] line_o,
  output logic [icachePkg::XLen-1:0]      bufferWord_o
);

  icachePkg::cacheAddrT            addrQ;
  logic                            reqQ;
  logic                            collectQ;
  logic [1:0]                      beatCnt;
  logic [icachePkg::LineWidth-1:0] bufferQ;
  logic                            beatTake;

  assign beatTake = collectQ && memDataValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqQ     <= 1'b0;
      collectQ <= 1'b0;
      beatCnt  <= '0;
    end else if (start_i) begin
      reqQ <= 1'b1;
    end else if (reqQ && memRdReady_i) begin
      // burst accepted, beats follow
      reqQ     <= 1'b0;
      collectQ <= 1'b1;
      beatCnt  <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 2'd1;
      if (memLast_i) begin
        collectQ <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      addrQ <= lineAddr_i;
    end
    if (beatTake) begin
      bufferQ[beatCnt*icachePkg::XLen +: icachePkg::XLen] <= memData_i;
    end
  end

  assign memRdValid_o = reqQ;
  assign memAddr_o    = {addrQ.f.tag, addrQ.f.index, {icachePkg::OffsetWidth{1'b0}}};
  assign done_o       = beatTake && memLast_i;
  assign line_o       = bufferQ;
  assign bufferWord_o = bufferQ[addrQ.f.beatSel*icachePkg::XLen +: icachePkg::XLen];

  // burst length is fixed at four beats
  aLastOnBeat3: assert property (@(posedge clk) disable iff (!rst_n)
    beatTake && memLast_i |-> beatCnt == 2'd3);

endmodule

// File: design/icacheCtrl.sv
module icacheCtrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       valid_i,
  input  icachePkg::cacheAddrT       addr_i,
  input  logic                       hold_i,
  output logic                       addrOk_o,
  output logic                       dataOk_o,
  output logic [icachePkg::XLen-1:0] rdData_o,
  output logic                       missBusy_o,
  input  logic                       cacheEn_i,
  input  logic                       flushReq_i,
  output logic                       flushDone_o,
  output logic                       hitPulse_o,
  output logic                       missPulse_o,
  input  logic                       way0Hit_i,
  input  logic                       way1Hit_i,
  input  logic                       victim_i,
  output icachePkg::cacheAddrT       lookupAddr_o,
  output logic                       tagWe_o,
  output logic                       flushAll_o,
  output logic                       dataWe_o,
  output logic                       weWay_o,
  output logic                       fillStart_o,
  input  logic                       fillDone_i,
  input  logic [icachePkg::XLen-1:0] bufferWord_i,
  input  logic [icachePkg::XLen-1:0] arrayWord_i
);

  logic [2:0]           stateQ;
  logic [2:0]           stateD;
  logic                 startedQ;
  logic                 filledQ;
  icachePkg::cacheAddrT reqQ;
  logic                 inIdle;
  logic                 inCompare;
  logic                 inReplace;
  logic                 dataReady;
  logic                 accept;

  assign inIdle    = stateQ == icachePkg::StIdle;
  assign inCompare = stateQ == icachePkg::StCompare;
  assign inReplace = stateQ == icachePkg::StReplace;

  // disabled cache only answers from the refill buffer
  assign dataReady = inCompare && (cacheEn_i ? (way0Hit_i || way1Hit_i) : filledQ);

  assign addrOk_o     = startedQ && ((inIdle && !flushReq_i) || (dataReady && !hold_i));
  assign accept       = valid_i && addrOk_o;
  assign lookupAddr_o = accept ? addr_i : reqQ;

  assign dataOk_o    = dataReady;
  assign rdData_o    = (!cacheEn_i && filledQ) ? bufferWord_i : arrayWord_i;
  assign missBusy_o  = (inCompare && !dataReady) || stateQ == icachePkg::StMiss ||
                       stateQ == icachePkg::StFetch || inReplace;
  // a word served after a refill was already counted as a miss
  assign hitPulse_o  = dataReady && !hold_i && !filledQ;
  assign missPulse_o = inCompare && !dataReady;

  assign fillStart_o = stateQ == icachePkg::StMiss;
  assign tagWe_o     = inReplace && cacheEn_i;
  assign dataWe_o    = inReplace && cacheEn_i;
  assign weWay_o     = victim_i;
  assign flushAll_o  = stateQ == icachePkg::StFlush;
  assign flushDone_o = stateQ == icachePkg::StFlush;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      icachePkg::StIdle: begin
        if (startedQ && flushReq_i) begin
          stateD = icachePkg::StFlush;
        end else if (accept) begin
          stateD = icachePkg::StCompare;
        end
      end
      icachePkg::StCompare: begin
        if (!dataReady) begin
          stateD = icachePkg::StMiss;
        end else if (!hold_i && !accept) begin
          stateD = icachePkg::StIdle;
        end
      end
      icachePkg::StMiss:    stateD = icachePkg::StFetch;
      icachePkg::StFetch: begin
        if (fillDone_i) begin
          stateD = icachePkg::StReplace;
        end
      end
      icachePkg::StReplace: stateD = icachePkg::StCompare;
      default:              stateD = icachePkg::StIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ   <= icachePkg::StIdle;
      startedQ <= 1'b0;
      filledQ  <= 1'b0;
      reqQ     <= '0;
    end else begin
      stateQ   <= stateD;
      startedQ <= 1'b1;
      reqQ     <= lookupAddr_o;
      if (inReplace) begin
        filledQ <= 1'b1;
      end else if (dataReady && !hold_i) begin
        filledQ <= 1'b0;
      end
    end
  end

  // the refill only completes while the FSM waits for it
  aFillInFetch: assert property (@(posedge clk) disable iff (!rst_n)
    fillDone_i |-> stateQ == icachePkg::StFetch);

endmodule

// File: design/icacheCfg.sv
module icacheCfg (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfgReq_i,
  input  logic        cfgWe_i,
  input  logic [1:0]  cfgAddr_i,
  input  logic [31:0] cfgWdata_i,
  output logic        cfgAck_o,
  output logic [31:0] cfgRdata_o,
  input  logic        hitPulse_i,
  input  logic        missPulse_i,
  input  logic        flushDone_i,
  output logic        cacheEn_o,
  output logic        flushReq_o
);

  logic [31:0] hitCntQ;
  logic [31:0] missCntQ;
  logic [31:0] rdataQ;
  logic        ackQ;
  logic        enQ;
  logic        flushQ;
  logic        newReq;
  logic        ctrlWrite;
  logic        flushWrite;

  // a request is taken once, before ack and outside a running flush
  assign newReq     = cfgReq_i && !ackQ && !flushQ;
  assign ctrlWrite  = newReq && cfgWe_i && cfgAddr_i == icachePkg::CfgCtrl;
  assign flushWrite = ctrlWrite && cfgWdata_i[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ackQ     <= 1'b0;
      enQ      <= 1'b1;
      flushQ   <= 1'b0;
      rdataQ   <= '0;
      hitCntQ  <= '0;
      missCntQ <= '0;
    end else begin
      // ack waits for the controller when a flush was asked for
      if (flushDone_i || (newReq && !flushWrite)) begin
        ackQ <= 1'b1;
      end else if (!cfgReq_i) begin
        ackQ <= 1'b0;
      end
      if (ctrlWrite) begin
        enQ <= cfgWdata_i[0];
      end
      if (flushWrite) begin
        flushQ <= 1'b1;
      end else if (flushDone_i) begin
        flushQ <= 1'b0;
      end
      if (newReq && !cfgWe_i) begin
        case (cfgAddr_i)
          icachePkg::CfgCtrl:      rdataQ <= {31'd0, enQ};
          icachePkg::CfgHitCount:  rdataQ <= hitCntQ;
          icachePkg::CfgMissCount: rdataQ <= missCntQ;
          default:                 rdataQ <= '0;
        endcase
      end
      // counters saturate at all ones
      if (newReq && cfgWe_i && cfgAddr_i == icachePkg::CfgHitCount) begin
        hitCntQ <= '0;
      end else if (hitPulse_i && hitCntQ != '1) begin
        hitCntQ <= hitCntQ + 32'd1;
      end
      if (newReq && cfgWe_i && cfgAddr_i == icachePkg::CfgMissCount) begin
        missCntQ <= '0;
      end else if (missPulse_i && missCntQ != '1) begin
        missCntQ <= missCntQ + 32'd1;
      end
    end
  end

  assign cfgAck_o   = ackQ;
  assign cfgRdata_o = rdataQ;
  assign cacheEn_o  = enQ;
  assign flushReq_o = flushQ;

endmodule

// File: design/icacheTop.sv
module icacheTop (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            valid_i,
  input  icachePkg::cacheAddrT            addr_i,
  input  logic                            hold_i,
  output logic                            addrOk_o,
  output logic                            dataOk_o,
  output logic [icachePkg::XLen-1:0]      rdData_o,
  output logic                            missBusy_o,
  output logic                            memRdValid_o,
  input  logic                            memRdReady_i,
  output logic [icachePkg::AddrWidth-1:0] memAddr_o,
  input  logic [icachePkg::XLen-1:0]      memData_i,
  input  logic                            memDataValid_i,
  input  logic                            memLast_i,
  input  logic                            cfgReq_i,
  input  logic                            cfgWe_i,
  input  logic [1:0]                      cfgAddr_i,
  input  logic [31:0]                     cfgWdata_i,
  output logic                            cfgAck_o,
  output logic [31:0]                     cfgRdata_o
);

  icachePkg::cacheAddrT            lookupAddr;
  logic                            way0Hit;
  logic                            way1Hit;
  logic                            victim;
  logic                            tagWe;
  logic                            flushAll;
  logic                            dataWe;
  logic                            weWay;
  logic                            fillStart;
  logic                            fillDone;
  logic [icachePkg::LineWidth-1:0] fillLine;
  logic [icachePkg::XLen-1:0]      bufferWord;
  logic [icachePkg::XLen-1:0]      arrayWord;
  logic                            cacheEn;
  logic                            flushReq;
  logic                            flushDone;
  logic                            hitPulse;
  logic                            missPulse;

  icacheCtrl icacheCtrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .hold_i       (hold_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .missBusy_o   (missBusy_o),
    .cacheEn_i    (cacheEn),
    .flushReq_i   (flushReq),
    .flushDone_o  (flushDone),
    .hitPulse_o   (hitPulse),
    .missPulse_o  (missPulse),
    .way0Hit_i    (way0Hit),
    .way1Hit_i    (way1Hit),
    .victim_i     (victim),
    .lookupAddr_o (lookupAddr),
    .tagWe_o      (tagWe),
    .flushAll_o   (flushAll),
    .dataWe_o     (dataWe),
    .weWay_o      (weWay),
    .fillStart_o  (fillStart),
    .fillDone_i   (fillDone),
    .bufferWord_i (bufferWord),
    .arrayWord_i  (arrayWord)
  );

  icacheTagArray icacheTagArray_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupAddr_i (lookupAddr),
    .tagWe_i      (tagWe),
    .weWay_i      (weWay),
    .flushAll_i   (flushAll),
    .way0Hit_o    (way0Hit),
    .way1Hit_o    (way1Hit),
    .victim_o     (victim)
  );

  // read and write both follow the lookup address
  icacheDataArray icacheDataArray_inst (
    .clk        (clk),
    .rdAddr_i   (lookupAddr),
    .wrAddr_i   (lookupAddr),
    .we_i       (dataWe),
    .weWay_i    (weWay),
    .lineData_i (fillLine),
    .hitWay1_i  (way1Hit),
    .word_o     (arrayWord)
  );

  icacheRefill icacheRefill_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (fillStart),
    .lineAddr_i     (lookupAddr),
    .memRdValid_o   (memRdValid_o),
    .memRdReady_i   (memRdReady_i),
    .memAddr_o      (memAddr_o),
    .memData_i      (memData_i),
    .memDataValid_i (memDataValid_i),
    .memLast_i      (memLast_i),
    .done_o         (fillDone),
    .line_o         (fillLine),
    .bufferWord_o   (bufferWord)
  );

  icacheCfg icacheCfg_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfgReq_i    (cfgReq_i),
    .cfgWe_i     (cfgWe_i),
    .cfgAddr_i   (cfgAddr_i),
    .cfgWdata_i  (cfgWdata_i),
    .cfgAck_o    (cfgAck_o),
    .cfgRdata_o  (cfgRdata_o),
    .hitPulse_i  (hitPulse),
    .missPulse_i (missPulse),
    .flushDone_i (flushDone),
    .cacheEn_o   (cacheEn),
    .flushReq_o  (flushReq)
  );

endmodule

// File: tb/tbIcache.sv
module tbIcache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WaitLimit = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 valid_i;
  icachePkg::cacheAddrT addr_i;
  logic                 hold_i;
  logic                 addrOk_o;
  logic                 dataOk_o;
  logic [63:0]          rdData_o;
  logic                 missBusy_o;
  logic                 memRdValid_o;
  logic                 memRdReady_i;
  logic [31:0]          memAddr_o;
  logic [63:0]          memData_i;
  logic                 memDataValid_i;
  logic                 memLast_i;
  logic                 cfgReq_i;
  logic                 cfgWe_i;
  logic [1:0]           cfgAddr_i;
  logic [31:0]          cfgWdata_i;
  logic                 cfgAck_o;
  logic [31:0]          cfgRdata_o;

  // reference model of tags, valid and round-robin bits
  logic [icachePkg::TagWidth-1:0] modelTag [2][icachePkg::NumSets];
  logic [icachePkg::NumSets-1:0]  modelValid [2];
  logic [icachePkg::NumSets-1:0]  modelRr;
  logic                           modelEn;
  int unsigned                    hitTally;
  int unsigned                    missTally;
  int unsigned                    errors;
  int unsigned                    checks;
  int unsigned                    testCount;
  int unsigned                    testErrStart;
  icachePkg::cacheAddrT           expQ [$];

  // memory model state
  int          memState;
  int          memDelay;
  int          memBeat;
  logic [31:0] burstAddr;
  int unsigned burstCount;
  logic [31:0] rngState;

  icacheTop icacheTop_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .hold_i         (hold_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .missBusy_o     (missBusy_o),
    .memRdValid_o   (memRdValid_o),
    .memRdReady_i   (memRdReady_i),
    .memAddr_o      (memAddr_o),
    .memData_i      (memData_i),
    .memDataValid_i (memDataValid_i),
    .memLast_i      (memLast_i),
    .cfgReq_i       (cfgReq_i),
    .cfgWe_i        (cfgWe_i),
    .cfgAddr_i      (cfgAddr_i),
    .cfgWdata_i     (cfgWdata_i),
    .cfgAck_o       (cfgAck_o),
    .cfgRdata_o     (cfgRdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // memory content of the 64-bit beat at byte address a
  function automatic logic [63:0] beatValue(input logic [31:0] a);
    return {a * 32'h9e37_79b9, a ^ 32'h5a5a_a5a5};
  endfunction

  function automatic logic [63:0] refWord(input icachePkg::cacheAddrT a);
    return beatValue({a.word[31:3], 3'b000});
  endfunction

  function automatic icachePkg::cacheAddrT makeAddr(input logic [20:0] tag,
                                                    input logic [5:0] idx,
                                                    input logic [1:0] beat);
    icachePkg::cacheAddrT a;
    a.f.tag     = tag;
    a.f.index   = idx;
    a.f.beatSel = beat;
    a.f.byteOff = 3'd0;
    return a;
  endfunction

  // predicts hit or miss and updates the model like a fill would
  function automatic logic predictAccess(input icachePkg::cacheAddrT a);
    logic hit;
    logic way;
    hit = 1'b0;
    if (!modelEn) begin
      missTally++;
      return 1'b0;
    end
    for (int w = 0; w < 2; w++) begin
      if (modelValid[w][a.f.index] && modelTag[w][a.f.index] == a.f.tag) begin
        hit = 1'b1;
      end
    end
    if (hit) begin
      hitTally++;
    end else begin
      missTally++;
      way = modelRr[a.f.index];
      modelTag[way][a.f.index]   = a.f.tag;
      modelValid[way][a.f.index] = 1'b1;
      modelRr[a.f.index]         = ~modelRr[a.f.index];
    end
    return hit;
  endfunction

  task automatic checkWord(input string name, input logic [icachePkg::XLen-1:0] got,
                           input logic [icachePkg::XLen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkHitMiss(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkReg(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic abortOnTimeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic startTest();
    testErrStart = errors;
  endtask

  task automatic endTest(input string name);
    testCount++;
    $display("%-20s %s", name, (errors == testErrStart) ? "passed" : "failed");
  endtask

  task automatic waitAccept();
    int n;
    n = 0;
    @(posedge clk);
    while (!(valid_i && addrOk_o)) begin
      if (n == WaitLimit) abortOnTimeout("the fetch request to be accepted");
      n++;
      @(posedge clk);
    end
  endtask

  task automatic waitDone();
    int n;
    n = 0;
    @(posedge clk);
    while (!(dataOk_o && !hold_i)) begin
      if (n == WaitLimit) abortOnTimeout("the fetch data to return");
      n++;
      @(posedge clk);
    end
  endtask

  // one fetch, counted as a hit when it caused no burst
  task automatic fetchCheck(input icachePkg::cacheAddrT addr);
    logic        expHit;
    int unsigned burstsBefore;
    expHit       = predictAccess(addr);
    burstsBefore = burstCount;
    @(posedge clk);
    valid_i <= 1'b1;
    addr_i  <= addr;
    waitAccept();
    valid_i <= 1'b0;
    expQ.push_back(addr);
    waitDone();
    checkHitMiss("hit", burstCount == burstsBefore, expHit);
    if (!expHit) begin
      checkReg("memAddr_o", burstAddr, {addr.word[31:5], 5'b0});
    end
  endtask

  // four-phase transfer on the config port
  task automatic cfgAccess(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int n;
    @(posedge clk);
    cfgReq_i   <= 1'b1;
    cfgWe_i    <= we;
    cfgAddr_i  <= addr;
    cfgWdata_i <= wdata;
    n = 0;
    @(posedge clk);
    while (!cfgAck_o) begin
      if (n == WaitLimit) abortOnTimeout("cfgAck_o to rise");
      n++;
      @(posedge clk);
    end
    rdata = cfgRdata_o;
    cfgReq_i <= 1'b0;
    n = 0;
    @(posedge clk);
    while (cfgAck_o) begin
      if (n == WaitLimit) abortOnTimeout("cfgAck_o to fall");
      n++;
      @(posedge clk);
    end
  endtask

  // burst memory that answers after 0 to 3 idle cycles
  always @(posedge clk) begin
    if (rst_n) begin
      case (memState)
        0: begin
          if (memRdValid_o) begin
            // the refill is running, so the fetch side must see it busy
            checkHitMiss("missBusy_o", missBusy_o, 1'b1);
            burstAddr  <= memAddr_o;
            burstCount <= burstCount + 1;
            rngState = xorshift32(rngState);
            memDelay   <= int'(rngState % 4);
            memState   <= 1;
          end
        end
        1: begin
          if (memDelay == 0) begin
            memRdReady_i <= 1'b1;
            memState     <= 2;
          end else begin
            memDelay <= memDelay - 1;
          end
        end
        2: begin
          // address taken on this edge
          memRdReady_i   <= 1'b0;
          memDataValid_i <= 1'b1;
          memData_i      <= beatValue(burstAddr);
          memLast_i      <= 1'b0;
          memBeat        <= 1;
          memState       <= 3;
        end
        default: begin
          if (memBeat < icachePkg::BeatsPerLine) begin
            memData_i <= beatValue(burstAddr + 32'(memBeat * 8));
            memLast_i <= memBeat == icachePkg::BeatsPerLine - 1;
            memBeat   <= memBeat + 1;
          end else begin
            memDataValid_i <= 1'b0;
            memLast_i      <= 1'b0;
            memState       <= 0;
          end
        end
      endcase
    end
  end

  // every cycle with dataOk_o is checked and the request retires once hold is low
  always @(posedge clk) begin
    if (rst_n && dataOk_o) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("dataOk_o was high with no fetch outstanding");
      end else begin
        checkWord("rdData_o", rdData_o, refWord(expQ[0]));
        if (!hold_i) begin
          void'(expQ.pop_front());
        end
      end
    end
  end

  initial begin
    logic [31:0]          rd;
    logic [63:0]          heldWord;
    logic                 expHit;
    int unsigned          burstsBefore;
    icachePkg::cacheAddrT lineA;
    rst_n          = 1'b0;
    valid_i        = 1'b0;
    addr_i         = '0;
    hold_i         = 1'b0;
    memRdReady_i   = 1'b0;
    memData_i      = '0;
    memDataValid_i = 1'b0;
    memLast_i      = 1'b0;
    cfgReq_i       = 1'b0;
    cfgWe_i        = 1'b0;
    cfgAddr_i      = '0;
    cfgWdata_i     = '0;
    memState       = 0;
    memDelay       = 0;
    memBeat        = 0;
    burstAddr      = '0;
    burstCount     = 0;
    rngState       = 32'hd448_668f;
    modelValid[0]  = '0;
    modelValid[1]  = '0;
    modelRr        = '0;
    modelEn        = 1'b1;
    hitTally       = 0;
    missTally      = 0;
    errors         = 0;
    checks         = 0;
    testCount      = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    startTest();
    @(posedge clk);
    checkHitMiss("addrOk_o", addrOk_o, 1'b0);
    checkHitMiss("dataOk_o", dataOk_o, 1'b0);
    checkHitMiss("memRdValid_o", memRdValid_o, 1'b0);
    checkHitMiss("cfgAck_o", cfgAck_o, 1'b0);
    checkHitMiss("missBusy_o", missBusy_o, 1'b0);
    cfgAccess(1'b0, icachePkg::CfgCtrl, 32'd0, rd);
    checkReg("ctrl register", rd, 32'd1);
    endTest("reset state");

    startTest();
    lineA = makeAddr(21'h2, 6'd2, 2'd1);
    fetchCheck(lineA);
    fetchCheck(makeAddr(21'h2, 6'd2, 2'd3));
    fetchCheck(makeAddr(21'h2, 6'd2, 2'd0));
    endTest("cold miss then hit");

    // three tags fighting over set 5
    startTest();
    fetchCheck(makeAddr(21'h10, 6'd5, 2'd0));
    fetchCheck(makeAddr(21'h11, 6'd5, 2'd1));
    fetchCheck(makeAddr(21'h12, 6'd5, 2'd2));
    fetchCheck(makeAddr(21'h11, 6'd5, 2'd3));
    fetchCheck(makeAddr(21'h10, 6'd5, 2'd0));
    fetchCheck(makeAddr(21'h12, 6'd5, 2'd1));
    fetchCheck(makeAddr(21'h11, 6'd5, 2'd2));
    endTest("two-way conflicts");

    startTest();
    expHit       = predictAccess(lineA);
    burstsBefore = burstCount;
    @(posedge clk);
    valid_i <= 1'b1;
    addr_i  <= lineA;
    waitAccept();
    expQ.push_back(lineA);
    // next request stays pending behind hold
    addr_i <= makeAddr(21'h3, 6'd2, 2'd0);
    hold_i <= 1'b1;
    @(posedge clk);
    heldWord = rdData_o;
    checkHitMiss("dataOk_o", dataOk_o, 1'b1);
    repeat (3) begin
      @(posedge clk);
      checkHitMiss("dataOk_o", dataOk_o, 1'b1);
      checkHitMiss("addrOk_o", addrOk_o, 1'b0);
      checkWord("rdData_o", rdData_o, heldWord);
    end
    hold_i  <= 1'b0;
    valid_i <= 1'b0;
    waitDone();
    checkHitMiss("hit", burstCount == burstsBefore, expHit);
    endTest("back-pressure");

    startTest();
    cfgAccess(1'b1, icachePkg::CfgCtrl, 32'h3, rd);
    modelValid[0] = '0;
    modelValid[1] = '0;
    fetchCheck(lineA);
    endTest("flush");

    // arrays stay untouched while disabled
    startTest();
    cfgAccess(1'b1, icachePkg::CfgCtrl, 32'h0, rd);
    modelEn = 1'b0;
    repeat (3) fetchCheck(lineA);
    cfgAccess(1'b1, icachePkg::CfgCtrl, 32'h1, rd);
    modelEn = 1'b1;
    fetchCheck(lineA);
    endTest("disable");

    startTest();
    cfgAccess(1'b0, icachePkg::CfgHitCount, 32'd0, rd);
    checkReg("hit counter", rd, hitTally);
    cfgAccess(1'b0, icachePkg::CfgMissCount, 32'd0, rd);
    checkReg("miss counter", rd, missTally);
    endTest("counters");

    $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/icachePkg.sv
design/icacheTagArray.sv
design/icacheDataArray.sv
design/icacheRefill.sv
design/icacheCtrl.sv
design/icacheCfg.sv
design/icacheTop.sv
tb/tbIcache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - design/icachePkg.sv
  - design/icacheTagArray.sv
  - design/icacheDataArray.sv
  - design/icacheRefill.sv
  - design/icacheCtrl.sv
  - design/icacheCfg.sv
  - design/icacheTop.sv
  - target: simulation
    files:
      - tb/tbIcache.sv
